// File: axi_mem_pkg.sv
package axi_mem_pkg;

  // Widths of the AXI4 fields used by the memory.
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;
  typedef logic [7:0]  len_t;
  typedef logic [2:0]  size_t;
  typedef logic [1:0]  burst_t;
  typedef logic [1:0]  resp_t;

  // Burst types as encoded on AxBURST.
  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR  = 2'd1;
  localparam burst_t BURST_WRAP  = 2'd2;

  // Only OKAY is ever returned.
  localparam resp_t RESP_OKAY = 2'd0;

  // Read address channel.
  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } ar_chan_t;

  // Write address channel, single beat writes only.
  typedef struct packed {
    addr_t addr;
  } aw_chan_t;

  // Write data channel.
  typedef struct packed {
    data_t data;
    strb_t strb;
  } w_chan_t;

  // Read data channel.
  typedef struct packed {
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  // Write response channel.
  typedef struct packed {
    resp_t resp;
  } b_chan_t;

endpackage

// File: axi_burst_addr.sv
module axi_burst_addr (
  input  axi_mem_pkg::addr_t  addr,
  input  axi_mem_pkg::len_t   len,
  input  axi_mem_pkg::size_t  size,
  input  axi_mem_pkg::burst_t burst,
  output axi_mem_pkg::addr_t  next_addr
);

  import axi_mem_pkg::*;

  logic [2:0] wrap_beats_log2;
  logic [3:0] wrap_log2;
  addr_t      wrap_mask;
  addr_t      incr_addr;

  // Log2 of the beat count; zero marks an illegal wrap length.
  always_comb begin
    case (len)
      8'd1:    wrap_beats_log2 = 3'd1;
      8'd3:    wrap_beats_log2 = 3'd2;
      8'd7:    wrap_beats_log2 = 3'd3;
      8'd15:   wrap_beats_log2 = 3'd4;
      default: wrap_beats_log2 = 3'd0;
    endcase
  end

  assign wrap_log2 = {1'b0, size} + {1'b0, wrap_beats_log2};
  assign wrap_mask = ~(addr_t'('1) << wrap_log2);
  assign incr_addr = addr + (addr_t'(1) << size);

  always_comb begin
    case (burst)
      BURST_INCR: next_addr = incr_addr;
      BURST_WRAP: begin
        if (wrap_beats_log2 == 3'd0) begin
          next_addr = addr;
        end else begin
          next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
        end
      end
      default:    next_addr = addr;
    endcase
  end

endmodule

// File: axi_mem_array.sv
module axi_mem_array #(
  parameter int mem_words = 1024
) (
  input                       clock,
  input                       rd_en,
  input  axi_mem_pkg::addr_t  rd_addr,
  output axi_mem_pkg::data_t  rd_data,
  input                       wr_en,
  input  axi_mem_pkg::addr_t  wr_addr,
  input  axi_mem_pkg::data_t  wr_data,
  input  axi_mem_pkg::strb_t  wr_strb
);

  import axi_mem_pkg::*;

  localparam int index_bits = $clog2(mem_words);

  data_t                 mem [mem_words];
  logic [index_bits-1:0] rd_index;
  logic [index_bits-1:0] wr_index;

  // Word index wraps at the memory depth.
  assign rd_index = rd_addr[3 +: index_bits];
  assign wr_index = wr_addr[3 +: index_bits];

  // Registered read port, holds its value between reads.
  always_ff @(posedge clock) begin
    if (rd_en) begin
      rd_data <= mem[rd_index];
    end
  end

  // A read of the word written on the same edge sees the old contents.
  always_ff @(posedge clock) begin
    if (wr_en) begin
      for (int i = 0; i < $bits(strb_t); i++) begin
        if (wr_strb[i]) begin
          mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

// File: axi_read_ctrl.sv
module axi_read_ctrl (
  input                         clock,
  input                         reset,
  input  axi_mem_pkg::ar_chan_t ar,
  input                         ar_valid,
  output logic                  ar_ready,
  output axi_mem_pkg::r_chan_t  r,
  output logic                  r_valid,
  input                         r_ready,
  output logic                  rd_en,
  output axi_mem_pkg::addr_t    rd_addr,
  input  axi_mem_pkg::data_t    rd_data
);

  import axi_mem_pkg::*;

  typedef enum logic {
    st_idle,
    st_burst
  } state_t;

  state_t state;
  len_t   beats_left;
  addr_t  cur_addr;
  len_t   cur_len;
  size_t  cur_size;
  burst_t cur_burst;
  addr_t  next_addr;
  logic   ar_fire;
  logic   r_fire;
  logic   last_beat;

  assign ar_ready  = (state == st_idle);
  assign r_valid   = (state == st_burst);
  assign ar_fire   = ar_valid && ar_ready;
  assign r_fire    = r_valid && r_ready;
  assign last_beat = (beats_left == '0);

  axi_burst_addr axi_burst_addr_i (
    .addr      (cur_addr),
    .len       (cur_len),
    .size      (cur_size),
    .burst     (cur_burst),
    .next_addr (next_addr)
  );

  // First beat is fetched on the AR transfer, later beats on each R transfer.
  assign rd_en   = ar_fire || (r_fire && !last_beat);
  assign rd_addr = ar_fire ? ar.addr : next_addr;

  // Data comes straight from the array, which holds while r_ready is low.
  assign r.data = rd_data;
  assign r.resp = RESP_OKAY;
  assign r.last = last_beat;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state      <= st_idle;
      beats_left <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (ar_fire) begin
            state      <= st_burst;
            beats_left <= ar.len;
          end
        end
        st_burst: begin
          if (r_fire) begin
            if (last_beat) begin
              state <= st_idle;
            end else begin
              beats_left <= beats_left - 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Burst parameters and the running address.
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      cur_addr  <= ar.addr;
      cur_len   <= ar.len;
      cur_size  <= ar.size;
      cur_burst <= ar.burst;
    end else if (r_fire && !last_beat) begin
      cur_addr <= next_addr;
    end
  end

endmodule

// File: axi_write_ctrl.sv
module axi_write_ctrl (
  input                         clock,
  input                         reset,
  input  axi_mem_pkg::aw_chan_t aw,
  input                         aw_valid,
  output logic                  aw_ready,
  input  axi_mem_pkg::w_chan_t  w,
  input                         w_valid,
  output logic                  w_ready,
  output axi_mem_pkg::b_chan_t  b,
  output logic                  b_valid,
  input                         b_ready,
  output logic                  wr_en,
  output axi_mem_pkg::addr_t    wr_addr,
  output axi_mem_pkg::data_t    wr_data,
  output axi_mem_pkg::strb_t    wr_strb
);

  import axi_mem_pkg::*;

  aw_chan_t aw_held;
  w_chan_t  w_held;
  logic     aw_stored;
  logic     w_stored;
  logic     b_stall;
  logic     aw_fire;
  logic     w_fire;
  logic     have_addr;
  logic     have_data;
  logic     write_en;

  // A pending response that is not taken blocks new writes.
  assign b_stall  = b_valid && !b_ready;
  assign aw_ready = !aw_stored && !b_stall;
  assign w_ready  = !w_stored && !b_stall;

  assign aw_fire   = aw_valid && aw_ready;
  assign w_fire    = w_valid && w_ready;
  assign have_addr = aw_fire || aw_stored;
  assign have_data = w_fire || w_stored;
  assign write_en  = have_addr && have_data;

  // Take each half from the live transfer if present, else from the stored copy.
  assign wr_en   = write_en;
  assign wr_addr = aw_fire ? aw.addr : aw_held.addr;
  assign wr_data = w_fire ? w.data : w_held.data;
  assign wr_strb = w_fire ? w.strb : w_held.strb;

  assign b.resp = RESP_OKAY;

  always_ff @(posedge clock) begin
    if (!reset) begin
      aw_stored <= 1'b0;
      w_stored  <= 1'b0;
      b_valid   <= 1'b0;
    end else begin
      if (write_en) begin
        aw_stored <= 1'b0;
        w_stored  <= 1'b0;
      end else begin
        if (aw_fire) begin
          aw_stored <= 1'b1;
        end
        if (w_fire) begin
          w_stored <= 1'b1;
        end
      end

      // A new write may complete on the same edge the old response leaves.
      if (write_en) begin
        b_valid <= 1'b1;
      end else if (b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  // Copies of a half that arrived before its partner.
  always_ff @(posedge clock) begin
    if (aw_fire) begin
      aw_held <= aw;
    end
    if (w_fire) begin
      w_held <= w;
    end
  end

endmodule

// File: axi_mem_top.sv
module axi_mem_top #(
  parameter int mem_words = 1024
) (
  input                         clock,
  input                         reset,
  input  axi_mem_pkg::ar_chan_t ar,
  input                         ar_valid,
  output logic                  ar_ready,
  output axi_mem_pkg::r_chan_t  r,
  output logic                  r_valid,
  input                         r_ready,
  input  axi_mem_pkg::aw_chan_t aw,
  input                         aw_valid,
  output logic                  aw_ready,
  input  axi_mem_pkg::w_chan_t  w,
  input                         w_valid,
  output logic                  w_ready,
  output axi_mem_pkg::b_chan_t  b,
  output logic                  b_valid,
  input                         b_ready
);

  import axi_mem_pkg::*;

  logic  rd_en;
  addr_t rd_addr;
  data_t rd_data;
  logic  wr_en;
  addr_t wr_addr;
  data_t wr_data;
  strb_t wr_strb;

  axi_read_ctrl axi_read_ctrl_i (
    .clock    (clock),
    .reset    (reset),
    .ar       (ar),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .r        (r),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  axi_write_ctrl axi_write_ctrl_i (
    .clock    (clock),
    .reset    (reset),
    .aw       (aw),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .w        (w),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .b        (b),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .wr_strb  (wr_strb)
  );

  axi_mem_array #(
    .mem_words (mem_words)
  ) axi_mem_array_i (
    .clock   (clock),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_strb (wr_strb)
  );

endmodule

// File: tb_axi_mem.sv
module tb_axi_mem;

  timeunit 1ns;
  timeprecision 1ps;

  import axi_mem_pkg::*;

  localparam int mem_words  = 1024;
  localparam int max_cycles = 200;

  logic     clock;
  logic     reset;
  ar_chan_t ar;
  logic     ar_valid;
  logic     ar_ready;
  r_chan_t  r;
  logic     r_valid;
  logic     r_ready;
  aw_chan_t aw;
  logic     aw_valid;
  logic     aw_ready;
  w_chan_t  w;
  logic     w_valid;
  logic     w_ready;
  b_chan_t  b;
  logic     b_valid;
  logic     b_ready;

  logic [31:0] rng_state = 32'h3691bee7;
  logic [31:0] gap_state = 32'h3691bee7;
  data_t       shadow [mem_words];
  data_t       exp_words [16];
  len_t        exp_len;
  data_t       exp_data;
  logic        exp_last;
  int          beat_idx;
  logic        read_active;
  int          aw_count;
  int          b_count;
  r_chan_t     r_prev;
  b_chan_t     b_prev;
  logic        r_held;
  logic        b_held;
  addr_t       test_addrs [40];
  len_t        incr_lens [3] = '{8'd0, 8'd3, 8'd15};
  len_t        wrap_lens [4] = '{8'd1, 8'd3, 8'd7, 8'd15};

  axi_mem_top #(
    .mem_words (mem_words)
  ) axi_mem_top_i (.*);

  function automatic logic [31:0] lcg_step(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = lcg_step(rng_state);
    return rng_state;
  endfunction

  function automatic int word_of(addr_t a);
    return int'((a >> 3) % mem_words);
  endfunction

  // Address of the beat after cur, from the AXI burst rules.
  function automatic addr_t next_beat_addr(addr_t cur, addr_t start, len_t len, size_t size,
                                           burst_t burst);
    addr_t step;
    addr_t span;
    addr_t base;
    step = addr_t'(1) << size;
    span = step * (addr_t'(len) + 1);
    if (burst == BURST_INCR) begin
      return cur + step;
    end
    if (burst == BURST_WRAP && (len == 1 || len == 3 || len == 7 || len == 15)) begin
      base = start & ~(span - 1);
      return base + ((cur - base + step) % span);
    end
    return start;
  endfunction

  task automatic abort_run(string reason);
    $display("%s at %0t ns", reason, $time);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(string name, logic [127:0] expected, logic [127:0] actual);
    $display("ERROR at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  // Ready is sampled mid-cycle and the transfer happens on the next rising edge.
  task automatic wait_ar();
    int n;
    n = 0;
    @(negedge clock);
    while (!ar_ready) begin
      n++;
      if (n > max_cycles) abort_run("Timeout waiting for the AR handshake");
      @(negedge clock);
    end
    @(posedge clock);
    ar_valid <= 1'b0;
  endtask

  task automatic wait_aw();
    int n;
    n = 0;
    @(negedge clock);
    while (!aw_ready) begin
      n++;
      if (n > max_cycles) abort_run("Timeout waiting for the AW handshake");
      @(negedge clock);
    end
    @(posedge clock);
    aw_valid <= 1'b0;
  endtask

  task automatic wait_w();
    int n;
    n = 0;
    @(negedge clock);
    while (!w_ready) begin
      n++;
      if (n > max_cycles) abort_run("Timeout waiting for the W handshake");
      @(negedge clock);
    end
    @(posedge clock);
    w_valid <= 1'b0;
  endtask

  task automatic wait_b();
    int n;
    n = 0;
    @(negedge clock);
    while (!(b_valid && b_ready)) begin
      n++;
      if (n > max_cycles) abort_run("Timeout waiting for the write response");
      @(negedge clock);
    end
    @(posedge clock);
  endtask

  task automatic wait_read_done();
    int n;
    n = 0;
    @(negedge clock);
    while (read_active) begin
      n++;
      if (n > max_cycles) abort_run("Timeout waiting for the last read beat");
      @(negedge clock);
    end
  endtask

  // Order 0 sends AW and W together, 1 sends AW first, 2 sends W first.
  task automatic write_word(addr_t addr, data_t data, strb_t strb, int order);
    @(posedge clock);
    if (order == 1) begin
      aw <= '{addr: addr};
      aw_valid <= 1'b1;
      wait_aw();
      w <= '{data: data, strb: strb};
      w_valid <= 1'b1;
      wait_w();
    end else if (order == 2) begin
      w <= '{data: data, strb: strb};
      w_valid <= 1'b1;
      wait_w();
      aw <= '{addr: addr};
      aw_valid <= 1'b1;
      wait_aw();
    end else begin
      aw <= '{addr: addr};
      aw_valid <= 1'b1;
      w <= '{data: data, strb: strb};
      w_valid <= 1'b1;
      fork
        wait_aw();
        wait_w();
      join
    end
    wait_b();
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        shadow[word_of(addr)][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  task automatic read_burst(addr_t addr, len_t len, size_t size, burst_t burst);
    addr_t a;
    a = addr;
    for (int k = 0; k <= len; k++) begin
      exp_words[k] = shadow[word_of(a)];
      a = next_beat_addr(a, addr, len, size, burst);
    end
    exp_len = len;
    @(posedge clock);
    ar <= '{addr: addr, len: len, size: size, burst: burst};
    ar_valid <= 1'b1;
    wait_ar();
    wait_read_done();
  endtask

  assign exp_data = exp_words[beat_idx];
  assign exp_last = (beat_idx == int'(exp_len));

  // Beat position, outstanding read and handshake counts.
  always_ff @(posedge clock) begin
    if (!reset) begin
      beat_idx    <= 0;
      read_active <= 1'b0;
      aw_count    <= 0;
      b_count     <= 0;
    end else begin
      if (ar_valid && ar_ready) read_active <= 1'b1;
      if (r_valid && r_ready) begin
        if (r.last) begin
          beat_idx    <= 0;
          read_active <= 1'b0;
        end else begin
          beat_idx <= beat_idx + 1;
        end
      end
      if (aw_valid && aw_ready) aw_count <= aw_count + 1;
      if (b_valid && b_ready) b_count <= b_count + 1;
    end
    r_prev <= r;
    b_prev <= b;
    r_held <= r_valid && !r_ready;
    b_held <= b_valid && !b_ready;
  end

  assert property (@(posedge clock) disable iff (!reset) r_held |-> r_valid)
    else abort_run("r_valid dropped before its beat was taken");
  assert property (@(posedge clock) disable iff (!reset) r_held |-> r == r_prev)
    else report_mismatch("r", $sampled(r_prev), $sampled(r));
  assert property (@(posedge clock) disable iff (!reset) b_held |-> b_valid)
    else abort_run("b_valid dropped before the response was taken");
  assert property (@(posedge clock) disable iff (!reset) b_held |-> b == b_prev)
    else report_mismatch("b", $sampled(b_prev), $sampled(b));
  assert property (@(posedge clock) disable iff (!reset) r_valid |-> r.resp == RESP_OKAY)
    else report_mismatch("r.resp", RESP_OKAY, $sampled(r.resp));
  assert property (@(posedge clock) disable iff (!reset) b_valid |-> b.resp == RESP_OKAY)
    else report_mismatch("b.resp", RESP_OKAY, $sampled(b.resp));
  assert property (@(posedge clock) disable iff (!reset) r_valid == read_active)
    else report_mismatch("r_valid", $sampled(read_active), $sampled(r_valid));
  assert property (@(posedge clock) disable iff (!reset) ar_ready == !read_active)
    else report_mismatch("ar_ready", $sampled(!read_active), $sampled(ar_ready));
  assert property (@(posedge clock) disable iff (!reset) b_valid && !b_ready |-> !aw_ready)
    else report_mismatch("aw_ready", 1'b0, $sampled(aw_ready));
  assert property (@(posedge clock) disable iff (!reset) b_valid && !b_ready |-> !w_ready)
    else report_mismatch("w_ready", 1'b0, $sampled(w_ready));
  assert property (@(posedge clock) disable iff (!reset) r_valid |-> r.data == exp_data)
    else report_mismatch("r.data", $sampled(exp_data), $sampled(r.data));
  assert property (@(posedge clock) disable iff (!reset) r_valid |-> r.last == exp_last)
    else report_mismatch("r.last", $sampled(exp_last), $sampled(r.last));
  assert property (@(posedge clock) disable iff (!reset) b_valid && b_ready |-> b_count < aw_count)
    else abort_run("Write response returned with no write outstanding");

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Random gaps on the response readies.
  initial begin
    forever begin
      @(posedge clock);
      gap_state = lcg_step(gap_state);
      r_ready <= gap_state[31:30] != 2'd0;
      gap_state = lcg_step(gap_state);
      b_ready <= gap_state[31:30] != 2'd0;
    end
  end

  initial begin
    reset    = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    repeat (8) @(posedge clock);
    reset <= 1'b1;

    // Every word gets a known value, cycling through the three write orders.
    for (int i = 0; i < mem_words; i++) begin
      write_word(addr_t'(i * 8), {rand32(), rand32()}, '1, i % 3);
    end

    for (int i = 0; i < 40; i++) begin
      test_addrs[i] = rand32();
      write_word(test_addrs[i], {rand32(), rand32()}, strb_t'(rand32() >> 24),
                 (rand32() >> 16) % 3);
    end
    for (int i = 0; i < 40; i++) begin
      read_burst(test_addrs[i], 8'd0, 3'd3, BURST_INCR);
    end

    for (int s = 2; s <= 3; s++) begin
      foreach (incr_lens[j]) read_burst(rand32(), incr_lens[j], size_t'(s), BURST_INCR);
    end

    // Odd start addresses keep the wrap bursts unaligned.
    for (int s = 0; s <= 3; s++) begin
      foreach (wrap_lens[j]) read_burst(rand32() | 32'h1, wrap_lens[j], size_t'(s), BURST_WRAP);
    end
    read_burst(rand32(), 8'd2, 3'd3, BURST_WRAP);

    read_burst(rand32(), 8'd3, 3'd2, BURST_FIXED);
    read_burst(rand32(), 8'd7, 3'd3, BURST_FIXED);

    for (int i = 0; i < 60; i++) begin
      if ((rand32() >> 31) != 0) begin
        write_word(rand32(), {rand32(), rand32()}, strb_t'(rand32() >> 24),
                   (rand32() >> 16) % 3);
      end else begin
        read_burst(rand32(), len_t'(rand32() >> 28), size_t'(rand32() >> 30),
                   burst_t'((rand32() >> 16) % 3));
      end
    end

    @(negedge clock);
    if (b_count != aw_count) begin
      report_mismatch("b_count", aw_count, b_count);
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// File: axi_mem.f
axi_mem_pkg.sv
axi_burst_addr.sv
axi_mem_array.sv
axi_read_ctrl.sv
axi_write_ctrl.sv
axi_mem_top.sv
tb_axi_mem.sv
